/* dcache.f */
design/dcache_pkg.sv
design/cache_frontend.sv
design/cache_memory.sv
design/cache_control.sv
design/cache_backend.sv
design/dcache_top.sv
testbench/tb_clock_gen.sv
testbench/tb_main_memory.sv
testbench/tb_dcache.sv

/* design/cache_backend.sv */
`timescale 1ns/100ps

module cache_backend #(
    parameter int word_off_w = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    // from the cache memory
    input  logic                             be_valid,
    input  logic                             be_refill,
    input  dcache_pkg::mem_req_t             be_req,
    output logic                             be_done,
    output logic                             fill_we,
    output logic [word_off_w-1:0]            fill_word,
    output logic [dcache_pkg::fe_data_w-1:0] fill_data,
    // main memory, rdata valid with mem_ready
    output logic                             mem_valid,
    output dcache_pkg::mem_req_t             mem_req,
    input  logic [dcache_pkg::fe_data_w-1:0] mem_rdata,
    input  logic                             mem_ready
);

    dcache_pkg::backend_state_e state;
    dcache_pkg::mem_req_t       req_q;
    logic [word_off_w-1:0]      word_cnt;
    logic                       accept;
    logic                       last_word;

    assign accept    = mem_valid & mem_ready;
    assign last_word = (state == dcache_pkg::write_through) || (&word_cnt);
    assign be_done   = accept & last_word;

    // refill words go straight up
    assign fill_we   = accept & (state == dcache_pkg::refill);
    assign fill_word = word_cnt;
    assign fill_data = mem_rdata;

    // refill reads are line aligned, offset from the counter
    always_comb begin
        mem_req = req_q;
        if (state == dcache_pkg::refill) begin
            mem_req.addr[word_off_w-1:0] = word_cnt;
            mem_req.wstrb = '0;
        end
    end

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= dcache_pkg::idle;
            mem_valid <= 1'b0;
            word_cnt  <= '0;
        end else begin
            case (state)
                dcache_pkg::idle: begin
                    if (be_valid) begin
                        if (be_refill) begin
                            state <= dcache_pkg::refill;
                        end else begin
                            state <= dcache_pkg::write_through;
                        end
                        mem_valid <= 1'b1;
                        word_cnt  <= '0;
                    end
                end
                dcache_pkg::refill: begin
                    if (accept) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (last_word) begin
                            state     <= dcache_pkg::idle;
                            mem_valid <= 1'b0;
                        end
                    end
                end
                dcache_pkg::write_through: begin
                    if (accept) begin
                        state     <= dcache_pkg::idle;
                        mem_valid <= 1'b0;
                    end
                end
                default: state <= dcache_pkg::idle;
            endcase
        end
    end

    // request copy, held while memory stalls
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::idle && be_valid) begin
            req_q <= be_req;
        end
    end

endmodule

/* design/cache_control.sv */
`timescale 1ns/100ps

module cache_control (
    input  logic                             clk,
    input  logic                             reset,
    // request from the front end, held until ctrl_ready
    input  logic                             ctrl_valid,
    input  dcache_pkg::ctrl_op_e             ctrl_op,
    input  logic                             ctrl_write,
    output logic                             ctrl_ready,
    output logic [dcache_pkg::fe_data_w-1:0] ctrl_rdata,
    // cache memory events
    input  logic                             hit_pulse,
    input  logic                             miss_pulse,
    output logic                             invalidate
);

    logic [31:0] hit_cnt;
    logic [31:0] miss_cnt;
    logic        access;

    // answer once per held request
    assign access = ctrl_valid & ~ctrl_ready;

    //////////////////////////////////////////////////
    // counters and handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit_cnt    <= '0;
            miss_cnt   <= '0;
            ctrl_ready <= 1'b0;
            invalidate <= 1'b0;
        end else begin
            // saturate at all ones
            if (hit_pulse && hit_cnt != '1) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            if (miss_pulse && miss_cnt != '1) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
            ctrl_ready <= access;
            // writes elsewhere are acked and dropped
            invalidate <= access && ctrl_write && (ctrl_op == dcache_pkg::ctrl_invalidate);
        end
    end

    // readout, zero for writes and unknown words
    always_ff @(posedge clk) begin
        if (access) begin
            if (ctrl_write) begin
                ctrl_rdata <= '0;
            end else begin
                case (ctrl_op)
                    dcache_pkg::ctrl_read_hits:   ctrl_rdata <= hit_cnt;
                    dcache_pkg::ctrl_read_misses: ctrl_rdata <= miss_cnt;
                    default:                      ctrl_rdata <= '0;
                endcase
            end
        end
    end

endmodule

/* design/cache_frontend.sv */
`timescale 1ns/100ps

module cache_frontend (
    input  logic                             clk,
    input  logic                             reset,
    // processor side, addr msb picks the control block
    input  logic [dcache_pkg::fe_addr_w:0]   addr,
    input  logic [dcache_pkg::fe_data_w-1:0] wdata,
    input  logic [dcache_pkg::fe_nbytes-1:0] wstrb,
    input  logic                             valid,
    output logic                             ready,
    output logic [dcache_pkg::fe_data_w-1:0] rdata,
    // cache memory side
    output logic                             data_valid,
    output dcache_pkg::cache_req_t           data_req,
    input  logic                             data_ready,
    input  logic [dcache_pkg::fe_data_w-1:0] data_rdata,
    // control block side
    output logic                             ctrl_valid,
    output dcache_pkg::ctrl_op_e             ctrl_op,
    output logic                             ctrl_write,
    input  logic                             ctrl_ready,
    input  logic [dcache_pkg::fe_data_w-1:0] ctrl_rdata
);

    logic                   armed;
    logic                   take;
    logic                   sel_ctrl;
    dcache_pkg::word_addr_t word_addr;

    assign sel_ctrl  = addr[dcache_pkg::fe_addr_w];
    assign word_addr = addr[dcache_pkg::fe_addr_w-1:dcache_pkg::fe_byte_w];
    // a held request is taken only once
    assign take      = valid & armed;

    // control word address to op
    function automatic dcache_pkg::ctrl_op_e decode_op(input dcache_pkg::word_addr_t wa);
        dcache_pkg::ctrl_op_e op;
        case (wa)
            'd0:     op = dcache_pkg::ctrl_read_hits;
            'd1:     op = dcache_pkg::ctrl_read_misses;
            'd2:     op = dcache_pkg::ctrl_invalidate;
            default: op = dcache_pkg::ctrl_none;
        endcase
        return op;
    endfunction

    //////////////////////////////////////////////////
    // request register, stage 0 to 1
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            armed      <= 1'b1;
            data_valid <= 1'b0;
            ctrl_valid <= 1'b0;
        end else begin
            if (take) begin
                armed <= 1'b0;
                if (sel_ctrl) begin
                    ctrl_valid <= 1'b1;
                end else begin
                    data_valid <= 1'b1;
                end
            end
            // re-arm once the answer went out
            if (ready) begin
                armed <= 1'b1;
            end
            if (data_ready) begin
                data_valid <= 1'b0;
            end
            if (ctrl_ready) begin
                ctrl_valid <= 1'b0;
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (take) begin
            data_req.addr  <= word_addr;
            data_req.wdata <= wdata;
            data_req.wstrb <= wstrb;
            ctrl_op        <= decode_op(word_addr);
            ctrl_write     <= |wstrb;
        end
    end

    //////////////////////////////////////////////////
    // response merge
    //////////////////////////////////////////////////

    assign ready = data_ready | ctrl_ready;
    assign rdata = ctrl_ready ? ctrl_rdata : data_rdata;

endmodule

/* design/cache_memory.sv */
`timescale 1ns/100ps

module cache_memory #(
    parameter int nlines_w   = 4,
    parameter int word_off_w = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    // registered request from the front end
    input  logic                             data_valid,
    input  dcache_pkg::cache_req_t           data_req,
    output logic                             data_ready,
    output logic [dcache_pkg::fe_data_w-1:0] data_rdata,
    // back end
    output logic                             be_valid,
    output logic                             be_refill,
    output dcache_pkg::mem_req_t             be_req,
    input  logic                             be_done,
    input  logic                             fill_we,
    input  logic [word_off_w-1:0]            fill_word,
    input  logic [dcache_pkg::fe_data_w-1:0] fill_data,
    // control block
    output logic                             hit_pulse,
    output logic                             miss_pulse,
    input  logic                             invalidate
);

    localparam int addr_w = $bits(dcache_pkg::word_addr_t);
    localparam int tag_w  = addr_w - nlines_w - word_off_w;
    localparam int nlines = 2 ** nlines_w;
    localparam int nwords = 2 ** (nlines_w + word_off_w);

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    logic [tag_w-1:0]               tag_mem [nlines];
    logic [nlines-1:0]              valid_bits;
    logic [dcache_pkg::fe_data_w-1:0] data_mem [nwords];

    // address split of the held request
    logic [tag_w-1:0]      req_tag;
    logic [nlines_w-1:0]   req_index;
    logic [word_off_w-1:0] req_off;

    logic hit;
    logic is_write;
    logic lookup;
    // set while the request waits on its own refill
    logic retry;
    // write-through word taken by memory
    logic wt_done;

    assign req_tag   = data_req.addr[addr_w-1 -: tag_w];
    assign req_index = data_req.addr[word_off_w +: nlines_w];
    assign req_off   = data_req.addr[word_off_w-1:0];

    assign hit      = valid_bits[req_index] && (tag_mem[req_index] == req_tag);
    assign is_write = |data_req.wstrb;
    // one lookup per pass, not while the back end is busy
    assign lookup   = data_valid && !data_ready && !be_valid;
    assign wt_done  = be_valid && !be_refill && be_done;

    // back end sees the held request as is, it aligns refills itself
    assign be_req.addr  = data_req.addr;
    assign be_req.wdata = data_req.wdata;
    assign be_req.wstrb = data_req.wstrb;

    //////////////////////////////////////////////////
    // lookup stage and miss handling
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_ready <= 1'b0;
            be_valid   <= 1'b0;
            be_refill  <= 1'b0;
            retry      <= 1'b0;
            hit_pulse  <= 1'b0;
            miss_pulse <= 1'b0;
            valid_bits <= '0;
        end else begin
            data_ready <= 1'b0;
            hit_pulse  <= 1'b0;
            miss_pulse <= 1'b0;
            if (invalidate) begin
                valid_bits <= '0;
            end
            if (lookup) begin
                if (is_write) begin
                    // every write goes to memory
                    be_valid  <= 1'b1;
                    be_refill <= 1'b0;
                end else if (hit) begin
                    data_ready <= 1'b1;
                    // second pass after a refill is not a new hit
                    hit_pulse  <= !retry;
                    retry      <= 1'b0;
                end else begin
                    be_valid   <= 1'b1;
                    be_refill  <= 1'b1;
                    miss_pulse <= 1'b1;
                    retry      <= 1'b1;
                    valid_bits[req_index] <= 1'b0;
                end
            end
            if (be_valid && be_done) begin
                be_valid <= 1'b0;
                if (be_refill) begin
                    // line complete, lookup repeats next cycle
                    valid_bits[req_index] <= 1'b1;
                end else begin
                    data_ready <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // tag and data arrays
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (lookup && !is_write && !hit) begin
            tag_mem[req_index] <= req_tag;
        end
        if (lookup && !is_write && hit) begin
            data_rdata <= data_mem[{req_index, req_off}];
        end
        // refill words arrive in order
        if (fill_we) begin
            data_mem[{req_index, fill_word}] <= fill_data;
        end
        // byte merge on a write hit, no allocate on a miss
        if (wt_done && hit) begin
            for (int b = 0; b < dcache_pkg::fe_nbytes; b++) begin
                if (data_req.wstrb[b]) begin
                    data_mem[{req_index, req_off}][8*b +: 8] <= data_req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

/* design/dcache_pkg.sv */
package dcache_pkg;

    //////////////////////////////////////////////////
    // front-end geometry
    //////////////////////////////////////////////////

    // byte address of the cache / memory space
    localparam int fe_addr_w = 16;
    localparam int fe_data_w = 32;
    localparam int fe_nbytes = fe_data_w / 8;
    // byte offset inside a word
    localparam int fe_byte_w = 2;

    // word address, byte offset dropped
    typedef logic [fe_addr_w-fe_byte_w-1:0] word_addr_t;

    //////////////////////////////////////////////////
    // request bundles
    //////////////////////////////////////////////////

    // registered request toward the cache memory
    typedef struct packed {
        word_addr_t             addr;
        logic [fe_data_w-1:0]   wdata;
        logic [fe_nbytes-1:0]   wstrb;
    } cache_req_t;

    // main-memory request, a write when wstrb is nonzero
    typedef struct packed {
        word_addr_t             addr;
        logic [fe_data_w-1:0]   wdata;
        logic [fe_nbytes-1:0]   wstrb;
    } mem_req_t;

    // control word decode
    typedef enum logic [1:0] {
        ctrl_read_hits   = 2'd0,
        ctrl_read_misses = 2'd1,
        ctrl_invalidate  = 2'd2,
        ctrl_none        = 2'd3
    } ctrl_op_e;

    // back-end sequencer
    typedef enum logic [1:0] {
        idle,
        refill,
        write_through
    } backend_state_e;

endpackage

/* design/dcache_top.sv */
`timescale 1ns/100ps

module dcache_top #(
    parameter int nlines_w   = 4,
    parameter int word_off_w = 2
) (
    input  logic                             clk,
    input  logic                             reset,
    // processor port, addr msb selects the control block
    input  logic [dcache_pkg::fe_addr_w:0]   addr,
    input  logic [dcache_pkg::fe_data_w-1:0] wdata,
    input  logic [dcache_pkg::fe_nbytes-1:0] wstrb,
    input  logic                             valid,
    output logic                             ready,
    output logic [dcache_pkg::fe_data_w-1:0] rdata,
    // main-memory port
    output logic                             mem_valid,
    output dcache_pkg::mem_req_t             mem_req,
    input  logic [dcache_pkg::fe_data_w-1:0] mem_rdata,
    input  logic                             mem_ready
);

    //////////////////////////////////////////////////
    // stage links
    //////////////////////////////////////////////////

    logic                             data_valid;
    dcache_pkg::cache_req_t           data_req;
    logic                             data_ready;
    logic [dcache_pkg::fe_data_w-1:0] data_rdata;
    logic                             ctrl_valid;
    dcache_pkg::ctrl_op_e             ctrl_op;
    logic                             ctrl_write;
    logic                             ctrl_ready;
    logic [dcache_pkg::fe_data_w-1:0] ctrl_rdata;
    logic                             be_valid;
    logic                             be_refill;
    dcache_pkg::mem_req_t             be_req;
    logic                             be_done;
    logic                             fill_we;
    logic [word_off_w-1:0]            fill_word;
    logic [dcache_pkg::fe_data_w-1:0] fill_data;
    logic                             hit_pulse;
    logic                             miss_pulse;
    logic                             invalidate;

    cache_frontend i_frontend (.*);

    cache_memory #(
        .nlines_w   (nlines_w),
        .word_off_w (word_off_w)
    ) i_memory (.*);

    cache_backend #(
        .word_off_w (word_off_w)
    ) i_backend (.*);

    cache_control i_control (.*);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f dcache.f --Mdir "$build_dir" -o sim_dcache
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/sim_dcache" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Verification passed" "$log_file"; then
    exit 0
fi
exit 1

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int period       = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release on a falling edge, away from the active edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* testbench/tb_dcache.sv */
`timescale 1ns/100ps

module tb_dcache;

    localparam int nlines_w       = 4;
    localparam int word_off_w     = 2;
    localparam int seed           = 94053;
    localparam int n_random       = 200;
    // 30 cycles per random access, 400 for the directed part
    localparam int timeout_cycles = n_random * 30 + 400;

    localparam int addr_w = $bits(dcache_pkg::word_addr_t);
    localparam int tag_w  = addr_w - nlines_w - word_off_w;
    localparam int nlines = 2 ** nlines_w;
    localparam int nwords = 2 ** addr_w;

    logic                             clk;
    logic                             reset;
    logic [dcache_pkg::fe_addr_w:0]   addr;
    logic [dcache_pkg::fe_data_w-1:0] wdata;
    logic [dcache_pkg::fe_nbytes-1:0] wstrb;
    logic                             valid;
    logic                             ready;
    logic [dcache_pkg::fe_data_w-1:0] rdata;
    logic                             mem_valid;
    dcache_pkg::mem_req_t             mem_req;
    logic [dcache_pkg::fe_data_w-1:0] mem_rdata;
    logic                             mem_ready;

    // reference model: memory image, tags, valid bits, counters
    logic [31:0]      shadow [nwords];
    logic [tag_w-1:0] sh_tag [nlines];
    logic             sh_valid [nlines];
    int               exp_hits = 0;
    int               exp_misses = 0;

    int   data_errors = 0;
    int   lat_errors = 0;
    int   mem_errors = 0;
    int   proto_errors = 0;
    int   cycles = 0;
    logic req_seen = 1'b0;

    tb_clock_gen #(.period(40), .reset_cycles(4)) i_clk (.clk(clk), .reset(reset));

    dcache_top #(
        .nlines_w   (nlines_w),
        .word_off_w (word_off_w)
    ) i_dut (.*);

    tb_main_memory #(.max_delay(3), .seed(seed)) i_mem (.*);

    //////////////////////////////////////////////////
    // port rules
    //////////////////////////////////////////////////

    // quiet until the first request
    assert property (@(posedge clk) disable iff (reset) !req_seen |-> !ready && !mem_valid)
        else begin
            proto_errors++;
            $display("ready or mem_valid went high before any request");
        end

    assert property (@(posedge clk) disable iff (reset) ready |-> $past(valid))
        else begin
            proto_errors++;
            $display("ready came without a request on valid");
        end

    // one-cycle ready pulse
    assert property (@(posedge clk) disable iff (reset) $past(ready) |-> !ready)
        else begin
            proto_errors++;
            $display("ready stayed high for more than one cycle");
        end

    // stalled memory request holds still
    assert property (@(posedge clk) disable iff (reset)
        $past(mem_valid && !mem_ready) |-> mem_valid && (mem_req == $past(mem_req)))
        else begin
            proto_errors++;
            $display("memory request changed or dropped before it was accepted");
        end

    assert property (@(posedge clk) disable iff (reset) mem_valid |-> !ready)
        else begin
            proto_errors++;
            $display("processor got ready while main memory was still busy");
        end

    //////////////////////////////////////////////////
    // address helpers
    //////////////////////////////////////////////////

    function automatic logic [nlines_w-1:0] index_of(input dcache_pkg::word_addr_t wa);
        return wa[word_off_w +: nlines_w];
    endfunction

    function automatic logic [tag_w-1:0] tag_of(input dcache_pkg::word_addr_t wa);
        return wa[addr_w-1 -: tag_w];
    endfunction

    // byte address from tag, line and word
    function automatic logic [dcache_pkg::fe_addr_w-1:0] compose_addr(
        input int tag, input int idx, input int off);
        dcache_pkg::word_addr_t wa;
        wa = {tag[tag_w-1:0], idx[nlines_w-1:0], off[word_off_w-1:0]};
        return {wa, {dcache_pkg::fe_byte_w{1'b0}}};
    endfunction

    function automatic logic [dcache_pkg::fe_addr_w:0] ctrl_addr(input int word);
        return {1'b1, word[addr_w-1:0], {dcache_pkg::fe_byte_w{1'b0}}};
    endfunction

    //////////////////////////////////////////////////
    // processor port tasks
    //////////////////////////////////////////////////

    // one request, held until ready, latency counted from the drive edge
    task automatic bus_access(input logic [dcache_pkg::fe_addr_w:0] a, input logic [31:0] wd,
                              input logic [3:0] ws, output logic [31:0] rd, output int lat);
        @(negedge clk);
        addr     = a;
        wdata    = wd;
        wstrb    = ws;
        valid    = 1'b1;
        req_seen = 1'b1;
        lat      = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ready);
        rd    = rdata;
        valid = 1'b0;
    endtask

    task automatic read_check(input logic [dcache_pkg::fe_addr_w-1:0] ba);
        dcache_pkg::word_addr_t wa;
        logic [31:0]            rd;
        int                     lat;
        logic                   exp_hit;
        wa      = ba[dcache_pkg::fe_addr_w-1:dcache_pkg::fe_byte_w];
        exp_hit = sh_valid[index_of(wa)] && (sh_tag[index_of(wa)] == tag_of(wa));
        bus_access({1'b0, ba}, '0, '0, rd, lat);
        assert (rd == shadow[wa]) else begin
            data_errors++;
            $display("error: rdata %h expected %h at addr %h", rd, shadow[wa], ba);
        end
        if (exp_hit) begin
            exp_hits++;
            assert (lat == 2) else begin
                lat_errors++;
                $display("read hit at %h answered after %0d cycles instead of 2", ba, lat);
            end
        end else begin
            exp_misses++;
            sh_tag[index_of(wa)]   = tag_of(wa);
            sh_valid[index_of(wa)] = 1'b1;
            assert (lat > 2) else begin
                lat_errors++;
                $display("read at %h answered like a hit but the line was not cached", ba);
            end
        end
    endtask

    // write-through, no allocate
    task automatic write_check(input logic [dcache_pkg::fe_addr_w-1:0] ba,
                               input logic [31:0] wd, input logic [3:0] ws);
        dcache_pkg::word_addr_t wa;
        logic [31:0]            rd;
        int                     lat;
        wa = ba[dcache_pkg::fe_addr_w-1:dcache_pkg::fe_byte_w];
        for (int b = 0; b < dcache_pkg::fe_nbytes; b++) begin
            if (ws[b]) begin
                shadow[wa][8*b +: 8] = wd[8*b +: 8];
            end
        end
        bus_access({1'b0, ba}, wd, ws, rd, lat);
        assert (lat > 2) else begin
            lat_errors++;
            $display("write at %h answered before main memory could take it", ba);
        end
        assert (i_mem.mem[wa] == shadow[wa]) else begin
            mem_errors++;
            $display("error: mem_req word %h holds %h expected %h", wa, i_mem.mem[wa], shadow[wa]);
        end
    endtask

    // word 0 hits, word 1 misses
    task automatic counter_check(input int word);
        logic [31:0] rd;
        int          lat;
        int          expected;
        expected = (word == 0) ? exp_hits : exp_misses;
        bus_access(ctrl_addr(word), '0, '0, rd, lat);
        assert (rd == expected) else begin
            data_errors++;
            $display("error: rdata %h expected %h for counter word %0d", rd, expected, word);
        end
        assert (lat == 2) else begin
            lat_errors++;
            $display("counter read answered after %0d cycles instead of 2", lat);
        end
    endtask

    task automatic control_write(input int word);
        logic [31:0] rd;
        int          lat;
        bus_access(ctrl_addr(word), '0, 4'hf, rd, lat);
        assert (lat == 2) else begin
            lat_errors++;
            $display("control write answered after %0d cycles instead of 2", lat);
        end
        // word 2 drops every line
        if (word == 2) begin
            for (int i = 0; i < nlines; i++) begin
                sh_valid[i] = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int sel;
        int tag;
        int idx;
        int off;
        addr  = '0;
        wdata = '0;
        wstrb = '0;
        valid = 1'b0;
        void'($urandom(seed));
        for (int i = 0; i < nlines; i++) begin
            sh_valid[i] = 1'b0;
            sh_tag[i]   = '0;
        end
        @(negedge reset);
        for (int a = 0; a < nwords; a++) begin
            shadow[a] = i_mem.mem[a];
        end
        // idle stretch, nothing may answer
        repeat (4) @(negedge clk);

        // miss fills the line, the rest of it hits
        read_check(compose_addr(1, 0, 0));
        for (int o = 1; o < 2 ** word_off_w; o++) begin
            read_check(compose_addr(1, 0, o));
        end
        read_check(compose_addr(1, 0, 0));
        // partial write on a hit, then on a miss
        write_check(compose_addr(1, 0, 1), 32'ha5a5_5a5a, 4'b0101);
        read_check(compose_addr(1, 0, 1));
        write_check(compose_addr(3, 1, 0), 32'h1234_5678, 4'b0010);
        read_check(compose_addr(3, 1, 0));
        read_check(compose_addr(3, 1, 0));
        // same index, other tag
        read_check(compose_addr(5, 0, 2));
        read_check(compose_addr(1, 0, 1));
        counter_check(0);
        counter_check(1);
        // unused control word, then invalidate
        control_write(3);
        control_write(2);
        read_check(compose_addr(1, 0, 1));
        read_check(compose_addr(3, 1, 0));
        counter_check(0);
        counter_check(1);

        // random mix on a few lines so that tags collide
        for (int n = 0; n < n_random; n++) begin
            sel = $urandom_range(99, 0);
            tag = $urandom_range(3, 0);
            idx = $urandom_range(2, 0);
            off = $urandom_range(2 ** word_off_w - 1, 0);
            if (sel < 60) begin
                read_check(compose_addr(tag, idx, off));
            end else if (sel < 85) begin
                write_check(compose_addr(tag, idx, off), $urandom, 4'($urandom_range(15, 1)));
            end else if (sel < 94) begin
                counter_check(sel % 2);
            end else begin
                control_write(2);
            end
        end

        repeat (4) @(negedge clk);
        $display("errors: data %0d, latency %0d, memory %0d, protocol %0d",
                 data_errors, lat_errors, mem_errors, proto_errors);
        if (data_errors + lat_errors + mem_errors + proto_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("run stopped after %0d cycles, the tests did not finish in time", cycles);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

/* testbench/tb_main_memory.sv */
`timescale 1ns/100ps

module tb_main_memory #(
    parameter int max_delay = 3,
    parameter int seed      = 94053
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             mem_valid,
    input  dcache_pkg::mem_req_t             mem_req,
    output logic [dcache_pkg::fe_data_w-1:0] mem_rdata = '0,
    output logic                             mem_ready = 1'b0
);

    localparam int nwords = 2 ** $bits(dcache_pkg::word_addr_t);

    logic [dcache_pkg::fe_data_w-1:0] mem [nwords];
    int unsigned                      wait_cnt = 0;
    logic                             busy = 1'b0;

    // every address bit feeds the word pattern
    function automatic logic [31:0] hash(input int unsigned a);
        logic [31:0] h;
        h = (a ^ 32'h5a5a_0000) * 32'h9e37_79b1;
        return h ^ (h >> 13);
    endfunction

    initial begin
        for (int a = 0; a < nwords; a++) begin
            mem[a] = hash(a);
        end
    end

    //////////////////////////////////////////////////
    // response side, driven on the falling edge
    //////////////////////////////////////////////////

    // stall lengths come from this one seeded process
    initial begin
        void'($urandom(seed));
        forever begin
            @(negedge clk or posedge reset);
            if (reset) begin
                mem_ready = 1'b0;
                busy      = 1'b0;
            end else if (mem_ready) begin
                // word was taken at the last rising edge
                mem_ready = 1'b0;
                busy      = 1'b0;
            end else if (mem_valid) begin
                // fresh request, pick its stall
                if (!busy) begin
                    busy     = 1'b1;
                    wait_cnt = $urandom_range(max_delay, 0);
                end
                if (wait_cnt == 0) begin
                    if (|mem_req.wstrb) begin
                        for (int b = 0; b < dcache_pkg::fe_nbytes; b++) begin
                            if (mem_req.wstrb[b]) begin
                                mem[mem_req.addr][8*b +: 8] = mem_req.wdata[8*b +: 8];
                            end
                        end
                    end else begin
                        mem_rdata = mem[mem_req.addr];
                    end
                    mem_ready = 1'b1;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
        end
    end

endmodule
